//--- vlog.f
source/hss_prbs_pkg.sv
source/hss_prbs_lfsr.sv
source/hss_frame_pack.sv
source/hss_frame_crc.sv
source/hss_prbs_top.sv
sim/hss_prbs_tb.sv

//--- Bender.yml
package:
  name: hss_prbs

sources:
  # rtl in compile order
  - files:
      - source/hss_prbs_pkg.sv
      - source/hss_prbs_lfsr.sv
      - source/hss_frame_pack.sv
      - source/hss_frame_crc.sv
      - source/hss_prbs_top.sv
  # testbench
  - target: test
    files:
      - sim/hss_prbs_tb.sv

//--- sim/hss_prbs_tb.sv
// testbench for the link test-pattern source
// drives run through directed and random on/off intervals and checks
// every out_word against a frame-level model built from the link rules
// a watchdog bounds the run
// the closing line gives the counts

`timescale 1ns/100ps

module hss_prbs_tb
  import hss_prbs_pkg::*;
;

  localparam int unsigned FRAME_LEN  = 8;
  localparam logic [15:0] LFSR_SEED  = 16'hACE1;
  localparam int          CLK_PERIOD = 8;
  localparam int          PHASES     = 48;
  localparam int          MAX_ON     = 4 * (FRAME_LEN + 2);
  localparam int          MAX_OFF    = 2 * (FRAME_LEN + 2);
  // upper bound on frame slots including the directed part
  localparam int          TEST_FRAMES = PHASES * 6 + 16;
  localparam int          WATCHDOG_NS = TEST_FRAMES * (FRAME_LEN + 2) * CLK_PERIOD + 2000;

  logic       tb_clk = 1'b0;
  logic       tb_rst;
  logic       run;
  link_word_t out_word;

  // model state
  int          busy;            // edges until pack samples run again
  bit          start_d;         // frame started at the last edge
  int          out_pos;         // slot on out_word, -1 when idle
  int          frames_started;
  int          hdr_seen;
  logic [15:0] model_lfsr;
  logic [15:0] model_crc;
  logic [11:0] exp_seq;
  int          errors;
  int          checks;

  hss_prbs_top #(
    .FRAME_LEN (FRAME_LEN),
    .LFSR_SEED (LFSR_SEED)
  ) u_hss_prbs_top (
    .tb_clk   (tb_clk),
    .tb_rst   (tb_rst),
    .run      (run),
    .out_word (out_word)
  );

  always #(CLK_PERIOD / 2) tb_clk = ~tb_clk;

  // ----------------------------------------------------------------------
  // reference functions
  // ----------------------------------------------------------------------
  // new bit from state bits 15, 13, 12 and 10 shifted in at bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // crc-16 over one word msb first with no final inversion
  function automatic logic [15:0] crc_word(input logic [15:0] acc, input logic [15:0] d);
    logic [15:0] c;
    c = acc;
    for (int i = 15; i >= 0; i--)
    begin
      if (c[15] ^ d[i])
        c = {c[14:0], 1'b0} ^ CRC_POLY;
      else
        c = {c[14:0], 1'b0};
    end
    return c;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // hold run at one level for a number of cycles
  task automatic hold_run(input logic level, input int cycles);
    run = level;
    repeat (cycles) @(negedge tb_clk);
  endtask

  // ----------------------------------------------------------------------
  // frame timing model
  // ----------------------------------------------------------------------
  // pack samples run when free, then stays busy for a whole frame
  // out slot 0 (header) shows one edge after the sampling edge
  always @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      busy           = 0;
      start_d        = 1'b0;
      out_pos        = -1;
      frames_started = 0;
    end
    else
    begin
      if (start_d)
        out_pos = 0;
      else if ((out_pos >= 0) && (out_pos < FRAME_LEN + 1))
        out_pos = out_pos + 1;
      else
        out_pos = -1;
      if ((busy == 0) && run)
      begin
        start_d = 1'b1;
        busy    = FRAME_LEN + 1;
        frames_started++;
      end
      else
      begin
        start_d = 1'b0;
        if (busy > 0)
          busy--;
      end
    end
  end

  // ----------------------------------------------------------------------
  // checker sampling mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge tb_clk)
  begin
    if (tb_rst)
    begin
      model_lfsr = LFSR_SEED;
      model_crc  = CRC_INIT;
      exp_seq    = 12'd0;
      if (out_word.valid !== 1'b0)
        report_error("valid set during reset");
    end
    else if (out_pos < 0)
    begin
      if (out_word.valid !== 1'b0)
        report_error($sformatf("unexpected valid word, kind %0d", out_word.kind));
    end
    else
    begin
      checks++;
      if (out_word.valid !== 1'b1)
        report_error($sformatf("valid missing in frame slot %0d", out_pos));
      if (out_word.last !== (out_pos == FRAME_LEN))
        report_error($sformatf("last is %b in frame slot %0d", out_word.last, out_pos));
      if (out_pos == 0)
      begin
        // header slot
        if (out_word.kind !== KIND_HDR)
          report_error($sformatf("kind %0d, expected header", out_word.kind));
        if (out_word.payload.hdr.frm_len !== 4'(FRAME_LEN))
          report_error($sformatf("frm_len %0d, expected %0d",
                                 out_word.payload.hdr.frm_len, FRAME_LEN));
        if (out_word.payload.hdr.seq !== exp_seq)
          report_error($sformatf("seq %0h, expected %0h", out_word.payload.hdr.seq, exp_seq));
        exp_seq   = exp_seq + 12'd1;
        model_crc = CRC_INIT;
      end
      else if (out_pos <= FRAME_LEN)
      begin
        if (out_word.kind !== KIND_DATA)
          report_error($sformatf("kind %0d, expected data", out_word.kind));
        if (out_word.payload.word !== model_lfsr)
          report_error($sformatf("data %h, expected %h", out_word.payload.word, model_lfsr));
        model_crc  = crc_word(model_crc, model_lfsr);
        model_lfsr = lfsr_step(model_lfsr);
      end
      else
      begin
        // trailer slot
        if (out_word.kind !== KIND_CRC)
          report_error($sformatf("kind %0d, expected crc", out_word.kind));
        if (out_word.payload.word !== model_crc)
          report_error($sformatf("crc %h, expected %h", out_word.payload.word, model_crc));
      end
    end
    if (!tb_rst && out_word.valid && (out_word.kind == KIND_HDR))
      hdr_seen++;
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial
  begin
    int on_len;
    int off_len;
    tb_rst   = 1'b1;
    run      = 1'b0;
    errors   = 0;
    checks   = 0;
    hdr_seen = 0;
    void'($urandom(32'h835));
    repeat (3) @(negedge tb_clk);
    tb_rst = 1'b0;

    // idle after reset and then a single-cycle run pulse
    hold_run(1'b0, 10);
    hold_run(1'b1, 1);
    hold_run(1'b0, 20);
    // three back-to-back frames
    hold_run(1'b1, 3 * (FRAME_LEN + 2));
    hold_run(1'b0, 20);
    // drop run mid-frame
    hold_run(1'b1, 5);
    hold_run(1'b0, 20);

    // random on/off intervals
    for (int p = 0; p < PHASES; p++)
    begin
      on_len  = 1 + ($urandom % MAX_ON);
      off_len = 1 + ($urandom % MAX_OFF);
      hold_run(1'b1, on_len);
      hold_run(1'b0, off_len);
    end

    // let the last frame drain
    while ((busy != 0) || start_d || (out_pos >= 0))
      @(negedge tb_clk);
    repeat (4) @(negedge tb_clk);

    if (hdr_seen != frames_started)
    begin
      errors++;
      $display("saw %0d headers but %0d frames were started", hdr_seen, frames_started);
    end
    $display("frames: %0d, checks: %0d, errors: %0d", frames_started, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, %0d of %0d frames seen", WATCHDOG_NS, hdr_seen,
             frames_started);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- source/hss_prbs_top.sv
// top level of the link test-pattern source
// LFSR -> frame packer -> CRC stage
// run starts and stops framing, out_word carries the link stream
// frame length and LFSR seed are set here and passed down

`timescale 1ns/100ps

module hss_prbs_top
  import hss_prbs_pkg::*;
#(
  // data words per frame, 1 to 15
  parameter int unsigned FRAME_LEN = 8,
  // nonzero LFSR start value
  parameter logic [15:0] LFSR_SEED = 16'hACE1
)
(
  input  logic       tb_clk,
  input  logic       tb_rst,

  input  logic       run,
  output link_word_t out_word
);

  // ----------------------------------------------------------------------
  // pipeline wires
  // ----------------------------------------------------------------------
  logic        lfsr_next;
  logic [15:0] lfsr_data;
  link_word_t  pack_word;

  // pattern source
  hss_prbs_lfsr #(
    .LFSR_SEED (LFSR_SEED)
  ) u_hss_prbs_lfsr (
    .tb_clk    (tb_clk),
    .tb_rst    (tb_rst),
    .next      (lfsr_next),
    .lfsr_data (lfsr_data)
  );

  // header, data and gap slots
  hss_frame_pack #(
    .FRAME_LEN (FRAME_LEN)
  ) u_hss_frame_pack (
    .tb_clk    (tb_clk),
    .tb_rst    (tb_rst),
    .run       (run),
    .lfsr_data (lfsr_data),
    .next      (lfsr_next),
    .pack_word (pack_word)
  );

  // crc trailer and output register
  hss_frame_crc u_hss_frame_crc (
    .tb_clk    (tb_clk),
    .tb_rst    (tb_rst),
    .pack_word (pack_word),
    .out_word  (out_word)
  );

endmodule

//--- source/hss_frame_crc.sv
// CRC stage for the link test-pattern source
// registers every link word with one cycle of latency and
// runs a CRC-16 over the data words of each frame
// the gap slot behind the last data word is filled with a
// KIND_CRC word that carries the final accumulator value
// the gap input is always invalid, so the slot is free

`timescale 1ns/100ps

module hss_frame_crc
  import hss_prbs_pkg::*;
(
  input  logic       tb_clk,
  input  logic       tb_rst,

  input  link_word_t pack_word,
  output link_word_t out_word
);

  // ----------------------------------------------------------------------
  // crc-16 update over one word, msb first
  // ----------------------------------------------------------------------
  function automatic logic [15:0] crc_update(input logic [15:0] crc_in,
                                             input logic [15:0] data);
    logic [15:0] crc;
    logic        fb;
    crc = crc_in;
    for (int i = 15; i >= 0; i--)
    begin
      fb  = crc[15] ^ data[i];
      crc = {crc[14:0], 1'b0};
      if (fb)
      begin
        crc = crc ^ CRC_POLY;
      end
    end
    return crc;
  endfunction

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  logic          hdr_in;
  logic          data_in;
  logic [15:0]   crc_acc;
  logic [15:0]   crc_nxt;
  logic          trailer_pend;   // gap slot coming up

  logic          valid_q;
  word_kind_t    kind_q;
  logic          last_q;
  link_payload_u payload_q;
  link_payload_u payload_nxt;

  assign hdr_in  = pack_word.valid && (pack_word.kind == KIND_HDR);
  assign data_in = pack_word.valid && (pack_word.kind == KIND_DATA);

  // accumulator restarts on every header
  always_comb
  begin
    crc_nxt = crc_acc;
    if (hdr_in)
    begin
      crc_nxt = CRC_INIT;
    end
    else if (data_in)
    begin
      crc_nxt = crc_update(crc_acc, pack_word.payload.word);
    end
  end

  // pass the input through, or the crc in the gap slot
  always_comb
  begin
    payload_nxt = pack_word.payload;
    if (!pack_word.valid)
    begin
      // crc_acc already holds the last data word here
      payload_nxt.word = crc_acc;
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      trailer_pend <= 1'b0;
      valid_q      <= 1'b0;
      kind_q       <= KIND_DATA;
      last_q       <= 1'b0;
    end
    else
    begin
      // armed for exactly one cycle, the gap
      trailer_pend <= pack_word.valid && pack_word.last;
      valid_q      <= pack_word.valid || trailer_pend;
      kind_q       <= pack_word.valid ? pack_word.kind : KIND_CRC;
      last_q       <= pack_word.valid && pack_word.last;
    end
  end

  always_ff @(posedge tb_clk)
  begin
    crc_acc   <= crc_nxt;
    payload_q <= payload_nxt;
  end

  assign out_word = '{valid: valid_q, kind: kind_q, last: last_q, payload: payload_q};

endmodule

//--- source/hss_frame_pack.sv
// frame packer for the link test-pattern source
// wraps LFSR words into frames of one header, FRAME_LEN data words
// and one empty gap slot
// run is sampled while idle and after each gap, and a started frame
// always runs to its end
// next is driven so that every latched data word is a fresh LFSR state

`timescale 1ns/100ps

module hss_frame_pack
  import hss_prbs_pkg::*;
#(
  parameter int unsigned FRAME_LEN = 8
)
(
  input  logic        tb_clk,
  input  logic        tb_rst,

  input  logic        run,

  // LFSR interface
  input  logic [15:0] lfsr_data,
  output logic        next,

  output link_word_t  pack_word
);

  // ----------------------------------------------------------------------
  // state and counters
  // ----------------------------------------------------------------------
  // state names what pack_word currently holds
  typedef enum logic [1:0]
  {
    IDLE = 2'd0,
    HDR  = 2'd1,
    DATA = 2'd2,
    GAP  = 2'd3
  } pack_state_t;

  // index of the final data word
  localparam logic [3:0] LAST_IDX = 4'(FRAME_LEN - 1);

  pack_state_t   state;
  pack_state_t   state_nxt;
  logic [3:0]    data_cnt;      // index of data word on output
  logic [3:0]    data_cnt_nxt;
  logic [11:0]   seq_cnt;
  logic          start_frame;

  // output word fields
  logic          valid_q;
  logic          valid_nxt;
  word_kind_t    kind_q;
  word_kind_t    kind_nxt;
  logic          last_q;
  logic          last_nxt;
  link_payload_u payload_q;
  link_payload_u payload_nxt;

  // run only matters between frames
  assign start_frame = ((state == IDLE) || (state == GAP)) && run;

  // step the LFSR on every edge that latches a data word
  // i.e. behind the header and behind every data word but the last
  assign next = (state == HDR) || ((state == DATA) && (data_cnt != LAST_IDX));

  // ----------------------------------------------------------------------
  // next-state and next-word logic
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt        = state;
    data_cnt_nxt     = data_cnt;
    valid_nxt        = 1'b0;
    kind_nxt         = KIND_DATA;
    last_nxt         = 1'b0;
    // data slots take the current LFSR state
    payload_nxt.word = lfsr_data;

    case (state)
      IDLE, GAP:
      begin
        if (start_frame)
        begin
          state_nxt                   = HDR;
          valid_nxt                   = 1'b1;
          kind_nxt                    = KIND_HDR;
          // header built through its own view of the payload
          payload_nxt.hdr.frm_len     = 4'(FRAME_LEN);
          payload_nxt.hdr.seq         = seq_cnt;
        end
        else
        begin
          state_nxt = IDLE;
        end
      end

      HDR:
      begin
        // first data word
        state_nxt    = DATA;
        data_cnt_nxt = 4'd0;
        valid_nxt    = 1'b1;
        last_nxt     = (LAST_IDX == 4'd0);
      end

      DATA:
      begin
        if (data_cnt == LAST_IDX)
        begin
          // empty slot for the crc trailer
          state_nxt = GAP;
        end
        else
        begin
          data_cnt_nxt = data_cnt + 4'd1;
          valid_nxt    = 1'b1;
          last_nxt     = ((data_cnt + 4'd1) == LAST_IDX);
        end
      end

      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      state    <= IDLE;
      data_cnt <= 4'd0;
      seq_cnt  <= 12'd0;
      valid_q  <= 1'b0;
      kind_q   <= KIND_DATA;
      last_q   <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      data_cnt <= data_cnt_nxt;
      valid_q  <= valid_nxt;
      kind_q   <= kind_nxt;
      last_q   <= last_nxt;
      // one count per header, wraps at 12 bits
      if (start_frame)
      begin
        seq_cnt <= seq_cnt + 12'd1;
      end
    end
  end

  // payload only means something when valid_q is set
  always_ff @(posedge tb_clk)
  begin
    payload_q <= payload_nxt;
  end

  assign pack_word = '{valid: valid_q, kind: kind_q, last: last_q, payload: payload_q};

endmodule

//--- source/hss_prbs_lfsr.sv
// 16-bit Fibonacci LFSR pattern generator
// steps once for every cycle in which next is high
// lfsr_data always shows the registered state, so a consumer
// samples the current value in the same cycle that it raises next
// reset loads the seed given by the top level

`timescale 1ns/100ps

module hss_prbs_lfsr
  import hss_prbs_pkg::*;
#(
  // must be nonzero or the register locks up
  parameter logic [15:0] LFSR_SEED = 16'hACE1
)
(
  input  logic        tb_clk,
  input  logic        tb_rst,

  // step request from the frame packer
  input  logic        next,

  // current state
  output logic [15:0] lfsr_data
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  logic [15:0] lfsr_state;
  logic        feedback;

  // ----------------------------------------------------------------------
  // feedback
  // ----------------------------------------------------------------------
  // xor of the tapped bits
  // taps come from the shared polynomial mask
  always_comb
  begin
    feedback = ^(lfsr_state & LFSR_TAPS);
  end

  // ----------------------------------------------------------------------
  // state register
  // ----------------------------------------------------------------------
  // shift left, new bit enters at bit 0
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      lfsr_state <= LFSR_SEED;
    end
    else if (next)
    begin
      lfsr_state <= {lfsr_state[14:0], feedback};
    end
  end

  // registered state straight out
  assign lfsr_data = lfsr_state;

endmodule

//--- source/hss_prbs_pkg.sv
// shared types and constants for the link test-pattern source
// holds the link word format, the payload views and the polynomials
// used by the LFSR and the CRC stage
// modules pull this in with a wildcard import in their header

package hss_prbs_pkg;

  // ----------------------------------------------------------------------
  // link word kinds
  // ----------------------------------------------------------------------
  // meaning of the payload of a valid link word
  typedef enum logic [1:0]
  {
    KIND_HDR  = 2'd0,
    KIND_DATA = 2'd1,
    KIND_CRC  = 2'd2
  } word_kind_t;

  // ----------------------------------------------------------------------
  // payload views
  // ----------------------------------------------------------------------
  // header reading of the 16-bit payload
  typedef struct packed
  {
    logic [3:0]  frm_len;   // data words in this frame
    logic [11:0] seq;       // frame sequence number
  } hdr_view_t;

  // one payload word, decoded as header or as plain data/crc
  typedef union packed
  {
    hdr_view_t   hdr;
    logic [15:0] word;
  } link_payload_u;

  // full link word as it moves down the pipeline
  typedef struct packed
  {
    logic          valid;   // per-cycle strobe
    word_kind_t    kind;
    logic          last;    // final data word of a frame
    link_payload_u payload;
  } link_word_t;

  // ----------------------------------------------------------------------
  // polynomials
  // ----------------------------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  // feedback taps sit on state bits 15, 13, 12 and 10
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  // ccitt crc-16, msb first
  localparam logic [15:0] CRC_POLY = 16'h1021;
  localparam logic [15:0] CRC_INIT = 16'hFFFF;

endpackage
